//--- tb/tile_stimulus.txt
// mask wen addr{e3,e2,e1,e0} wdata_e0 wdata_e1 wdata_e2 wdata_e3 rdata_e0 rdata_e1 rdata_e2 rdata_e3
// mask and wen hold one bit per engine, rdata columns are expected values for reads only
f f 03020100 0123456789abcdef fedcba9876543210 a5a5a5a55a5a5a5a 0f0f0f0ff0f0f0f0 0 0 0 0
4 0 00000000 0 0 0 0 0 0 0123456789abcdef 0
1 1 00000010 deadbeefcafef00d 0 0 0 0 0 0 0
8 0 10000000 0 0 0 0 0 0 0 deadbeefcafef00d
f 0 00010203 0 0 0 0 0f0f0f0ff0f0f0f0 a5a5a5a55a5a5a5a fedcba9876543210 0123456789abcdef
f 5 03121011 1122334455667788 0 99aabbccddeeff00 0 0 deadbeefcafef00d 0 0f0f0f0ff0f0f0f0
6 2 00111300 0 8000000000000001 0 0 0 0 1122334455667788 0
b 0 10001312 0 0 0 0 99aabbccddeeff00 8000000000000001 0 deadbeefcafef00d
f f 17161514 ffffffff00000000 00000000ffffffff 5555aaaa5555aaaa 3c3c3c3cc3c3c3c3 0 0 0 0
f 0 14151617 0 0 0 0 3c3c3c3cc3c3c3c3 5555aaaa5555aaaa 00000000ffffffff ffffffff00000000
1 1 00000000 0badc0de0badc0de 0 0 0 0 0 0 0
2 0 00000000 0 0 0 0 0 0badc0de0badc0de 0 0
c 4 01180000 0 0 13579bdf2468ace0 0 0 0 0 fedcba9876543210
9 0 11000018 0 0 0 0 13579bdf2468ace0 0 0 1122334455667788
5 5 001e001f fedcba9801234567 0 c0ffee00c0ffee00 0 0 0 0 0
a 0 1e001f00 0 0 0 0 0 fedcba9801234567 0 c0ffee00c0ffee00
f 0 12121212 0 0 0 0 99aabbccddeeff00 99aabbccddeeff00 99aabbccddeeff00 99aabbccddeeff00
7 7 00060502 0000111122223333 4444555566667777 88889999aaaabbbb 0 0 0 0 0
e 0 05020600 0 0 0 0 0 88889999aaaabbbb 0000111122223333 4444555566667777
f a 1b131a1f 0 cccccccc33333333 0 1234123412341234 fedcba9801234567 0 8000000000000001 0

//--- sources.f
src/mp64_fabric_pkg.sv
src/mp64_line_mem.sv
src/mp64_tile_arbiter.sv
src/mp64_tile_fabric.sv
tb/tb_mp64_tile_fabric.sv

//--- Makefile
# Verilator build and regression run for the tile fabric

TOP := tb_mp64_tile_fabric

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_mp64_tile_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mp64_tile_fabric;

    // ==================================================
    // Sizes
    // ==================================================

    localparam int NT = mp64_fabric_pkg::NUM_TILES;
    localparam int AW = mp64_fabric_pkg::LINE_ADDR_BITS;
    localparam int DW = mp64_fabric_pkg::LINE_BITS;

    // Record is mask, wen, packed addr, then wdata and expected per engine
    localparam int NUM_RECS     = 20;
    localparam int REC_WORDS    = 3 + 2 * NT;
    localparam int RAND_OPS     = 60;
    localparam int RESET_CYCLES = 16;

    logic             sys_clk;
    logic             sys_rst_n;
    logic [NT-1:0]    tile_req;
    logic [NT*AW-1:0] tile_addr;
    logic [NT-1:0]    tile_wen;
    logic [NT*DW-1:0] tile_wdata;
    wire  [DW-1:0]    tile_rdata;
    wire  [NT-1:0]    tile_ack;

    // Raw stimulus words
    logic [DW-1:0] stim [NUM_RECS*REC_WORDS];

    // Outstanding operation per engine
    logic [NT-1:0] pending;
    logic [AW-1:0] op_addr  [NT];
    logic          op_wen   [NT];
    logic [DW-1:0] op_wdata [NT];
    logic [DW-1:0] op_exp   [NT];
    logic          from_file;

    // Memory model and round-robin model
    logic [DW-1:0] model_mem   [mp64_fabric_pkg::MEM_LINES];
    logic          model_valid [mp64_fabric_pkg::MEM_LINES];
    int            model_last;
    int            ack_log [$];

    int            issued;
    int            cycle_count;
    int            cycle_limit;
    logic [31:0]   lcg_state;

    mp64_tile_fabric dut (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .tile_req   (tile_req),
        .tile_addr  (tile_addr),
        .tile_wen   (tile_wen),
        .tile_wdata (tile_wdata),
        .tile_rdata (tile_rdata),
        .tile_ack   (tile_ack)
    );

    // 40 ns period
    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    // Watchdog, limit comes from the op count at time zero
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge sys_clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: traffic did not complete within %0d cycles", cycle_limit);
                $display("Regression failed");
                $fatal(1, "watchdog expired");
            end
        end
    end

    // ==================================================
    // Helpers
    // ==================================================

    task automatic check_value(input string name, input logic [DW-1:0] actual,
                               input logic [DW-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Numerical Recipes LCG step
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // True three times out of four
    function automatic logic coin();
        logic [31:0] r;
        r = lcg_next();
        return r[27] | r[26];
    endfunction

    // First requester after last, wrapping back to last itself
    function automatic int predict_grant(input logic [NT-1:0] reqs, input int last);
        int cand;
        for (int off = 1; off <= NT; off++) begin
            cand = (last + off) % NT;
            if (reqs[cand]) begin
                return cand;
            end
        end
        return -1;
    endfunction

    task automatic load_record(input int r);
        int b;
        b = r * REC_WORDS;
        pending = stim[b][NT-1:0];
        for (int i = 0; i < NT; i++) begin
            op_wen[i]   = stim[b+1][i];
            op_addr[i]  = stim[b+2][i*AW +: AW];
            op_wdata[i] = stim[b+3+i];
            op_exp[i]   = stim[b+3+NT+i];
        end
    endtask

    // Reads only go to lines the model already holds
    task automatic issue_random(input int i);
        logic [31:0] r;
        r = lcg_next();
        op_addr[i]  = AW'(r[20:16]);
        op_wen[i]   = r[24] || !model_valid[op_addr[i]];
        op_wdata[i] = {lcg_next(), lcg_next()};
        pending[i]  = 1'b1;
        issued++;
    endtask

    // Present requests and fields on the next rising edge
    task automatic drive_edge();
        logic [NT*AW-1:0] addr_bus;
        logic [NT-1:0]    wen_bus;
        logic [NT*DW-1:0] wdata_bus;
        for (int i = 0; i < NT; i++) begin
            addr_bus[i*AW +: AW]  = op_addr[i];
            wen_bus[i]            = op_wen[i];
            wdata_bus[i*DW +: DW] = op_wdata[i];
        end
        @(posedge sys_clk);
        tile_req   <= pending;
        tile_addr  <= addr_bus;
        tile_wen   <= wen_bus;
        tile_wdata <= wdata_bus;
    endtask

    // Mid-cycle look at the acks, score the one that fired
    task automatic sample_cycle(output logic [NT-1:0] acked);
        int            pred;
        logic [DW-1:0] want;
        @(negedge sys_clk);
        acked = tile_ack;
        check_value("tile_ack onehot", 64'($onehot0(tile_ack)), 64'd1);
        for (int i = 0; i < NT; i++) begin
            if (tile_ack[i]) begin
                check_value("tile_req at ack", 64'(pending[i]), 64'd1);
                pred = predict_grant(tile_req, model_last);
                check_value("tile_ack grant index", 64'(i), 64'(pred));
                model_last = i;
                ack_log.push_back(i);
                if (op_wen[i]) begin
                    model_mem[op_addr[i]]   = op_wdata[i];
                    model_valid[op_addr[i]] = 1'b1;
                end else begin
                    want = from_file ? op_exp[i] : model_mem[op_addr[i]];
                    check_value("tile_rdata", tile_rdata, want);
                end
                // Dropped on the edge that ends the ack cycle
                pending[i] = 1'b0;
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        logic [NT-1:0] acked;
        int            first_order;
        sys_rst_n  <= 1'b0;
        tile_req   <= '0;
        tile_addr  <= '0;
        tile_wen   <= '0;
        tile_wdata <= '0;
        pending     = '0;
        from_file   = 1'b1;
        model_last  = 0;
        issued      = 0;
        lcg_state   = 32'd96;
        cycle_limit = 8 * (NUM_RECS + RAND_OPS) * NT + RESET_CYCLES;
        for (int a = 0; a < mp64_fabric_pkg::MEM_LINES; a++) begin
            model_valid[a] = 1'b0;
        end
        $readmemh("tb/tile_stimulus.txt", stim);
        if (stim[(NUM_RECS-1)*REC_WORDS] == '0 || $isunknown(stim[(NUM_RECS-1)*REC_WORDS])) begin
            $display("Stimulus file tb/tile_stimulus.txt holds fewer records than expected");
            $display("Regression failed");
            $fatal(1, "stimulus load");
        end

        // No ack during reset or right after it
        repeat (RESET_CYCLES) begin
            @(negedge sys_clk);
            check_value("tile_ack", 64'(tile_ack), 64'd0);
        end
        @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(negedge sys_clk);
        check_value("tile_ack", 64'(tile_ack), 64'd0);

        // File records, engines in the mask start together
        for (int r = 0; r < NUM_RECS; r++) begin
            load_record(r);
            drive_edge();
            while (pending != '0) begin
                sample_cycle(acked);
                drive_edge();
            end
            // Fresh arbiter starts its scan after engine 0
            if (r == 0) begin
                first_order = (ack_log[0] << 12) | (ack_log[1] << 8) |
                              (ack_log[2] << 4) | ack_log[3];
                check_value("tile_ack order", 64'(first_order), 64'h1230);
            end
        end

        // Random traffic with immediate re-requests
        from_file = 1'b0;
        for (int i = 0; i < NT; i++) begin
            if (coin() || (i == NT - 1 && pending == '0)) begin
                issue_random(i);
            end
        end
        drive_edge();
        while (pending != '0) begin
            sample_cycle(acked);
            // New work only on ack edges, so the idle scan sees it all
            if (acked != '0) begin
                for (int i = 0; i < NT; i++) begin
                    if (!pending[i] && issued < RAND_OPS && coin()) begin
                        issue_random(i);
                    end
                end
                if (pending == '0 && issued < RAND_OPS) begin
                    issue_random(model_last);
                end
            end
            drive_edge();
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/mp64_tile_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module mp64_tile_fabric (
    input  wire                                                            sys_clk,
    input  wire                                                            sys_rst_n,

    // Four tile engines, flat-packed, engine i in slice i
    input  wire [mp64_fabric_pkg::NUM_TILES-1:0]                           tile_req,
    input  wire [mp64_fabric_pkg::NUM_TILES*mp64_fabric_pkg::LINE_ADDR_BITS-1:0] tile_addr,
    input  wire [mp64_fabric_pkg::NUM_TILES-1:0]                           tile_wen,
    input  wire [mp64_fabric_pkg::NUM_TILES*mp64_fabric_pkg::LINE_BITS-1:0] tile_wdata,

    // Shared read line plus per-engine ack
    output wire [mp64_fabric_pkg::LINE_BITS-1:0]                           tile_rdata,
    output wire [mp64_fabric_pkg::NUM_TILES-1:0]                           tile_ack
);

    // ==================================================
    // Arbiter to memory port
    // ==================================================

    wire                                       mem_req;
    wire [mp64_fabric_pkg::LINE_ADDR_BITS-1:0] mem_addr;
    wire                                       mem_wen;
    wire [mp64_fabric_pkg::LINE_BITS-1:0]      mem_wdata;
    wire [mp64_fabric_pkg::LINE_BITS-1:0]      mem_rdata;
    wire                                       mem_ack;

    // ==================================================
    // Round-robin arbiter
    // ==================================================

    // Four engines in, one memory port out
    mp64_tile_arbiter u_arbiter (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .tile_req   (tile_req),
        .tile_addr  (tile_addr),
        .tile_wen   (tile_wen),
        .tile_wdata (tile_wdata),
        .tile_rdata (tile_rdata),
        .tile_ack   (tile_ack),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_wen    (mem_wen),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

    // ==================================================
    // Shared line memory
    // ==================================================

    // Fixed one-cycle response
    mp64_line_mem u_line_mem (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wen   (mem_wen),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

endmodule

`default_nettype wire

//--- src/mp64_tile_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mp64_tile_arbiter (
    input  wire                                                            sys_clk,
    input  wire                                                            sys_rst_n,

    // Tile engine side, flat-packed with engine i in slice i
    input  wire [mp64_fabric_pkg::NUM_TILES-1:0]                           tile_req,
    input  wire [mp64_fabric_pkg::NUM_TILES*mp64_fabric_pkg::LINE_ADDR_BITS-1:0] tile_addr,
    input  wire [mp64_fabric_pkg::NUM_TILES-1:0]                           tile_wen,
    input  wire [mp64_fabric_pkg::NUM_TILES*mp64_fabric_pkg::LINE_BITS-1:0] tile_wdata,
    output logic [mp64_fabric_pkg::LINE_BITS-1:0]                          tile_rdata,
    output logic [mp64_fabric_pkg::NUM_TILES-1:0]                          tile_ack,

    // Shared memory port
    output logic                                                           mem_req,
    output logic [mp64_fabric_pkg::LINE_ADDR_BITS-1:0]                     mem_addr,
    output logic                                                           mem_wen,
    output logic [mp64_fabric_pkg::LINE_BITS-1:0]                          mem_wdata,
    input  wire  [mp64_fabric_pkg::LINE_BITS-1:0]                          mem_rdata,
    input  wire                                                            mem_ack
);

    // ==================================================
    // Arbiter state
    // ==================================================

    // Engine currently owning the memory port
    logic [mp64_fabric_pkg::TILE_ID_BITS-1:0] grant;
    // Engine served most recently, scan starts after it
    logic [mp64_fabric_pkg::TILE_ID_BITS-1:0] last_grant;
    // Port owned, waiting for mem_ack
    logic                                     busy;

    // Scan result
    logic [mp64_fabric_pkg::TILE_ID_BITS-1:0] next_grant;
    logic                                     any_req;

    // ==================================================
    // Round-robin scan
    // ==================================================

    // Order is last+1, last+2, last+3, then last itself
    // Walk offsets from far to near so the nearest hit is kept
    always_comb begin
        logic [mp64_fabric_pkg::TILE_ID_BITS-1:0] cand;
        next_grant = last_grant;
        any_req    = 1'b0;
        cand       = last_grant;
        for (int off = mp64_fabric_pkg::NUM_TILES; off >= 1; off--) begin
            // Offset NUM_TILES wraps back to last_grant
            cand = last_grant + off[mp64_fabric_pkg::TILE_ID_BITS-1:0];
            if (tile_req[cand]) begin
                next_grant = cand;
                any_req    = 1'b1;
            end
        end
    end

    // Grant register with busy held until the memory answers
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            grant      <= '0;
            last_grant <= '0;
            busy       <= 1'b0;
        end else if (busy) begin
            // Release on the ack edge, regrant one edge later
            if (mem_ack) begin
                busy       <= 1'b0;
                last_grant <= grant;
            end
        end else if (any_req) begin
            grant <= next_grant;
            busy  <= 1'b1;
        end
    end

    // ==================================================
    // Memory port mux
    // ==================================================

    // Request held for the whole busy window
    assign mem_req   = busy;
    assign mem_addr  = tile_addr[grant*mp64_fabric_pkg::LINE_ADDR_BITS +:
                                 mp64_fabric_pkg::LINE_ADDR_BITS];
    assign mem_wen   = tile_wen[grant];
    assign mem_wdata = tile_wdata[grant*mp64_fabric_pkg::LINE_BITS +:
                                  mp64_fabric_pkg::LINE_BITS];

    // ==================================================
    // Response routing
    // ==================================================

    // Read data goes to everyone, only the owner sees the ack
    assign tile_rdata = mem_rdata;

    always_comb begin
        for (int t = 0; t < mp64_fabric_pkg::NUM_TILES; t++) begin
            tile_ack[t] = mem_ack && (grant == t[mp64_fabric_pkg::TILE_ID_BITS-1:0]);
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Memory answers only while a grant is outstanding
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        mem_ack |-> busy);

    // Owner keeps its request up until acknowledged
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        busy |-> tile_req[grant]);

endmodule

`default_nettype wire

//--- src/mp64_line_mem.sv
`timescale 1ns/1ps
`default_nettype none

module mp64_line_mem (
    input  wire                                        sys_clk,
    input  wire                                        sys_rst_n,

    // Single request port from the tile arbiter
    input  wire                                        mem_req,
    input  wire  [mp64_fabric_pkg::LINE_ADDR_BITS-1:0] mem_addr,
    input  wire                                        mem_wen,
    input  wire  [mp64_fabric_pkg::LINE_BITS-1:0]      mem_wdata,
    output logic [mp64_fabric_pkg::LINE_BITS-1:0]      mem_rdata,
    output logic                                       mem_ack
);

    // ==================================================
    // Storage
    // ==================================================

    // MEM_LINES lines with contents undefined after reset
    logic [mp64_fabric_pkg::LINE_BITS-1:0] lines [mp64_fabric_pkg::MEM_LINES];

    // New request rather than the tail of the one being acked
    logic accept;

    assign accept = mem_req && !mem_ack;

    // ==================================================
    // Access
    // ==================================================

    // Write the line or latch read data on acceptance
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            if (mem_wen) begin
                lines[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= lines[mem_addr];
            end
        end
    end

    // One-cycle ack pulse after acceptance
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= accept;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Requester holds the port through its ack cycle
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        mem_ack |-> mem_req);

endmodule

`default_nettype wire

//--- src/mp64_fabric_pkg.sv
`default_nettype none

package mp64_fabric_pkg;

    // ==================================================
    // Tile port sizing
    // ==================================================

    // Tile engines sharing the single memory port
    localparam int NUM_TILES = 4;

    // Grant index width, must cover NUM_TILES
    localparam int TILE_ID_BITS = 2;

    // ==================================================
    // Line memory geometry
    // ==================================================

    // One memory line, moved whole per request
    localparam int LINE_BITS = 64;

    // Line address width into the shared memory
    localparam int LINE_ADDR_BITS = 8;

    // Memory depth in lines, 2**LINE_ADDR_BITS
    localparam int MEM_LINES = 256;

endpackage

`default_nettype wire
